//--- hw/htif_pkg.sv
`default_nettype none

package htif_pkg;

  // ------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------
  localparam int AXI_ADDR_W  = 32;
  localparam int AXI_ID_W    = 12;
  localparam int AXI_DATA_W  = 32;
  localparam int REG_IDX_LSB = 2;   // Byte address to word index
  localparam int REG_IDX_W   = 5;
  localparam int FIFO_DEPTH  = 32;
  localparam int COUNT_W     = 6;   // One extra bit so a full FIFO reads 32
  localparam int HOST_W      = 16;

  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  typedef logic [REG_IDX_W-1:0]  reg_idx_t;
  typedef logic [COUNT_W-1:0]    fifo_count_t;
  typedef logic [HOST_W-1:0]     host_half_t;

  // ------------------------------------------------------------------
  // Register map
  // ------------------------------------------------------------------
  localparam reg_idx_t DCOUNT_IDX = 5'd0;   // Read side
  localparam reg_idx_t RFIFO_IDX  = 5'd1;
  localparam reg_idx_t WFIFO_IDX  = 5'd0;   // Write side
  localparam reg_idx_t RESET_IDX  = 5'd31;

  // AR and AW beats share one layout
  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_ADDR_W-1:0] addr;
  } axi_addr_beat_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    axi_data_t           data;
  } axi_read_beat_t;

  // Second chip value in the upper half
  typedef struct packed {
    host_half_t hi;
    host_half_t lo;
  } host_pair_t;

endpackage

`default_nettype wire

//--- hw/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type payload_t = htif_pkg::axi_data_t
) (
  input  logic                  userclk2,
  input  logic                  reset,
  input  logic                  wren,
  input  logic                  rden,
  input  payload_t              din,
  output payload_t              dout,
  output logic                  full,
  output logic                  empty,
  output htif_pkg::fifo_count_t count
);

  import htif_pkg::*;

  payload_t mem [FIFO_DEPTH];

  // Pointers are one bit narrower than the count and wrap at FIFO_DEPTH
  logic [COUNT_W-2:0] wr_ptr;
  logic [COUNT_W-2:0] rd_ptr;
  fifo_count_t        count_q;
  logic               do_write;
  logic               do_read;

  assign full  = (count_q == fifo_count_t'(FIFO_DEPTH));
  assign empty = (count_q == '0);
  assign count = count_q;

  // Write when full only alongside a read
  assign do_write = wren && (!full || rden);
  assign do_read  = rden && !empty;

  assign dout = mem[rd_ptr];   // Show-ahead head

  // ------------------------------------------------------------------
  // Pointers and count
  // ------------------------------------------------------------------
  always_ff @(posedge userclk2)
  begin
    if (reset)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end
    else
    begin
      if (do_write)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_read)
        rd_ptr <= rd_ptr + 1'b1;

      if (do_write && !do_read)
        count_q <= count_q + 1'b1;
      else if (do_read && !do_write)
        count_q <= count_q - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge userclk2)
  begin
    if (do_write)
      mem[wr_ptr] <= din;
  end

endmodule

`default_nettype wire

//--- hw/host_in_path.sv
`timescale 1ns/1ps
`default_nettype none

module host_in_path (
  input  logic                 userclk2,
  input  logic                 reset,
  input  logic                 in_push,
  input  htif_pkg::axi_data_t  in_word,
  input  logic                 host_in_ready,
  output logic                 in_full,
  output logic                 host_in_valid,
  output htif_pkg::host_half_t host_in_bits
);

  import htif_pkg::*;

  axi_data_t head;
  logic      fifo_empty;
  logic      half_sel;    // 0 presents the low half
  logic      half_taken;
  logic      pop;

  sync_fifo #(
    .payload_t (axi_data_t)
  ) u_fifo (
    .userclk2 (userclk2),
    .reset    (reset),
    .wren     (in_push),
    .rden     (pop),
    .din      (in_word),
    .dout     (head),
    .full     (in_full),
    .empty    (fifo_empty),
    .count    ()
  );

  assign host_in_valid = !fifo_empty;
  assign half_taken    = host_in_valid && host_in_ready;
  assign pop           = half_taken && half_sel;   // Word leaves with its high half

  assign host_in_bits = half_sel ? head[AXI_DATA_W-1:HOST_W] : head[HOST_W-1:0];

  always_ff @(posedge userclk2)
  begin
    if (reset)
      half_sel <= 1'b0;
    else if (half_taken)
      half_sel <= ~half_sel;
  end

endmodule

`default_nettype wire

//--- hw/host_out_path.sv
`timescale 1ns/1ps
`default_nettype none

module host_out_path (
  input  logic                  userclk2,
  input  logic                  reset,
  input  logic                  host_out_valid,
  input  htif_pkg::host_half_t  host_out_bits,
  input  logic                  out_pop,
  output logic                  host_out_ready,
  output htif_pkg::fifo_count_t out_count,
  output htif_pkg::host_pair_t  out_head
);

  import htif_pkg::*;

  host_half_t first_q;    // First value of the pending pair
  host_pair_t pair;
  logic       pair_pos;   // Set once the first value is held
  logic       take;
  logic       push;
  logic       fifo_full;

  assign host_out_ready = !fifo_full;
  assign take           = host_out_valid && host_out_ready;
  assign push           = take && pair_pos;

  assign pair.hi = host_out_bits;
  assign pair.lo = first_q;

  sync_fifo #(
    .payload_t (host_pair_t)
  ) u_fifo (
    .userclk2 (userclk2),
    .reset    (reset),
    .wren     (push),
    .rden     (out_pop),
    .din      (pair),
    .dout     (out_head),
    .full     (fifo_full),
    .empty    (),
    .count    (out_count)
  );

  // ------------------------------------------------------------------
  // Pair assembly
  // ------------------------------------------------------------------
  always_ff @(posedge userclk2)
  begin
    if (reset)
      pair_pos <= 1'b0;
    else if (take)
      pair_pos <= ~pair_pos;
  end

  always_ff @(posedge userclk2)
  begin
    if (take && !pair_pos)
      first_q <= host_out_bits;
  end

endmodule

`default_nettype wire

//--- hw/axi_reg_port.sv
`timescale 1ns/1ps
`default_nettype none

module axi_reg_port (
  input  logic                           userclk2,
  input  logic                           reset,
  // Read address and data
  input  htif_pkg::axi_addr_beat_t       ar,
  input  logic                           arvalid,
  output logic                           arready,
  output htif_pkg::axi_read_beat_t       r,
  output logic                           rvalid,
  input  logic                           rready,
  // Write address, data and response
  input  logic                           awvalid,
  input  htif_pkg::axi_addr_beat_t       aw,
  input  logic                           wvalid,
  input  htif_pkg::axi_data_t            wdata,
  output logic                           awready,
  output logic                           wready,
  output logic [htif_pkg::AXI_ID_W-1:0]  bid,
  output logic                           bvalid,
  input  logic                           bready,
  // Host paths
  input  logic                           in_full,
  output logic                           in_push,
  output htif_pkg::axi_data_t            in_word,
  input  htif_pkg::fifo_count_t          out_count,
  input  htif_pkg::host_pair_t           out_head,
  output logic                           out_pop,
  output logic                           core_reset
);

  import htif_pkg::*;

  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } rd_state_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_WRITE,
    WR_ACK
  } wr_state_t;

  rd_state_t           rd_state;
  reg_idx_t            rd_idx;
  logic [AXI_ID_W-1:0] rd_id;
  axi_data_t           rd_data;
  logic                ar_fire;

  wr_state_t           wr_state;
  reg_idx_t            wr_idx;
  logic [AXI_ID_W-1:0] wr_id;
  axi_data_t           wr_data;
  logic                wr_go;
  logic                wr_fire;

  // ------------------------------------------------------------------
  // Read FSM
  // ------------------------------------------------------------------
  assign ar_fire = arvalid && arready;

  always_ff @(posedge userclk2)
  begin
    if (reset)
    begin
      rd_state <= RD_IDLE;
      rd_idx   <= '0;
      arready  <= 1'b0;   // Rises one cycle after reset
    end
    else
    begin
      case (rd_state)
        RD_IDLE:
        begin
          arready <= !ar_fire;
          if (ar_fire)
          begin
            rd_state <= RD_DATA;
            rd_idx   <= ar.addr[REG_IDX_LSB +: REG_IDX_W];
          end
        end
        default:
        begin
          arready <= rready;
          if (rready)
            rd_state <= RD_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge userclk2)
  begin
    if (ar_fire)
      rd_id <= ar.id;
  end

  assign rvalid = (rd_state == RD_DATA);
  assign r.id   = rd_id;
  assign r.data = rd_data;

  // Count is zero-extended, unmapped indices read zero
  always_comb
  begin
    case (rd_idx)
      DCOUNT_IDX: rd_data = axi_data_t'(out_count);
      RFIFO_IDX:  rd_data = out_head;
      default:    rd_data = '0;
    endcase
  end

  assign out_pop = rvalid && rready && (rd_idx == RFIFO_IDX);

  // ------------------------------------------------------------------
  // Write FSM
  // ------------------------------------------------------------------
  assign wr_go   = (wr_idx != WFIFO_IDX) || !in_full;   // Back-pressure on host_in
  assign wr_fire = (wr_state == WR_WRITE) && wr_go;

  always_ff @(posedge userclk2)
  begin
    if (reset)
    begin
      wr_state <= WR_IDLE;
      wr_idx   <= '0;
    end
    else
    begin
      case (wr_state)
        WR_IDLE:
        begin
          if (awvalid && wvalid)
          begin
            wr_state <= WR_WRITE;
            wr_idx   <= aw.addr[REG_IDX_LSB +: REG_IDX_W];
          end
        end
        WR_WRITE:
        begin
          if (wr_go)
            wr_state <= WR_ACK;
        end
        default:
        begin
          if (bready)
            wr_state <= WR_IDLE;
        end
      endcase
    end
  end

  // Beat capture
  always_ff @(posedge userclk2)
  begin
    if (wr_state == WR_IDLE && awvalid && wvalid)
    begin
      wr_id   <= aw.id;
      wr_data <= wdata;
    end
  end

  assign awready    = wr_fire;
  assign wready     = wr_fire;
  assign in_push    = wr_fire && (wr_idx == WFIFO_IDX);
  assign in_word    = wr_data;
  assign core_reset = wr_fire && (wr_idx == RESET_IDX);   // One-cycle pulse
  assign bvalid     = (wr_state == WR_ACK);
  assign bid        = wr_id;

endmodule

`default_nettype wire

//--- hw/htif_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module htif_bridge (
  input  logic                          userclk2,
  input  logic                          reset,
  // AXI from the ARM master port
  input  htif_pkg::axi_addr_beat_t      ar,
  input  logic                          arvalid,
  output logic                          arready,
  output htif_pkg::axi_read_beat_t      r,
  output logic                          rvalid,
  input  logic                          rready,
  input  htif_pkg::axi_addr_beat_t      aw,
  input  logic                          awvalid,
  output logic                          awready,
  input  htif_pkg::axi_data_t           wdata,
  input  logic                          wvalid,
  output logic                          wready,
  output logic [htif_pkg::AXI_ID_W-1:0] bid,
  output logic                          bvalid,
  input  logic                          bready,
  // Test chip side
  output logic                          host_in_valid,
  input  logic                          host_in_ready,
  output htif_pkg::host_half_t          host_in_bits,
  input  logic                          host_out_valid,
  output logic                          host_out_ready,
  input  htif_pkg::host_half_t          host_out_bits,
  output logic                          core_reset
);

  import htif_pkg::*;

  logic        in_push;
  axi_data_t   in_word;
  logic        in_full;
  logic        out_pop;
  fifo_count_t out_count;
  host_pair_t  out_head;

  axi_reg_port u_reg_port (
    .userclk2   (userclk2),
    .reset      (reset),
    .ar         (ar),
    .arvalid    (arvalid),
    .arready    (arready),
    .r          (r),
    .rvalid     (rvalid),
    .rready     (rready),
    .awvalid    (awvalid),
    .aw         (aw),
    .wvalid     (wvalid),
    .wdata      (wdata),
    .awready    (awready),
    .wready     (wready),
    .bid        (bid),
    .bvalid     (bvalid),
    .bready     (bready),
    .in_full    (in_full),
    .in_push    (in_push),
    .in_word    (in_word),
    .out_count  (out_count),
    .out_head   (out_head),
    .out_pop    (out_pop),
    .core_reset (core_reset)
  );

  // ARM to chip
  host_in_path u_host_in (
    .userclk2      (userclk2),
    .reset         (reset),
    .in_push       (in_push),
    .in_word       (in_word),
    .host_in_ready (host_in_ready),
    .in_full       (in_full),
    .host_in_valid (host_in_valid),
    .host_in_bits  (host_in_bits)
  );

  // Chip to ARM
  host_out_path u_host_out (
    .userclk2       (userclk2),
    .reset          (reset),
    .host_out_valid (host_out_valid),
    .host_out_bits  (host_out_bits),
    .out_pop        (out_pop),
    .host_out_ready (host_out_ready),
    .out_count      (out_count),
    .out_head       (out_head)
  );

endmodule

`default_nettype wire

//--- bench/htif_bridge_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module htif_bridge_asserts (
  input logic userclk2,
  input logic reset,
  input logic rvalid,
  input logic rready,
  input logic awvalid,
  input logic wvalid,
  input logic awready,
  input logic bvalid,
  input logic core_reset
);

  // Read data stays up until taken
  rvalid_hold: assert property (@(posedge userclk2) disable iff (reset)
    (rvalid && !rready) |=> rvalid)
    else $error("rvalid dropped before rready");

  reset_pulse: assert property (@(posedge userclk2) disable iff (reset)
    core_reset |=> !core_reset)
    else $error("core_reset lasted more than one cycle");

  // Accept only a beat that is still offered
  aw_w_accept: assert property (@(posedge userclk2) disable iff (reset)
    awready |-> (awvalid && wvalid))
    else $error("awready high without a pending write beat");

  // Accept and respond never overlap
  no_ready_in_ack: assert property (@(posedge userclk2) disable iff (reset)
    !(awready && bvalid))
    else $error("awready high together with bvalid");

endmodule

bind axi_reg_port htif_bridge_asserts u_asserts (
  .userclk2   (userclk2),
  .reset      (reset),
  .rvalid     (rvalid),
  .rready     (rready),
  .awvalid    (awvalid),
  .wvalid     (wvalid),
  .awready    (awready),
  .bvalid     (bvalid),
  .core_reset (core_reset)
);

`default_nettype wire

//--- bench/htif_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module htif_bridge_tb;

  import htif_pkg::*;

  localparam int PERIOD       = 100;
  localparam int RESET_CYCLES = 8;
  localparam int STEP_CYCLES  = 80;   // Watchdog budget per table entry

  // Table operation kinds
  localparam logic [2:0] OP_WRITE = 3'd0;
  localparam logic [2:0] OP_READ  = 3'd1;
  localparam logic [2:0] OP_PAIRS = 3'd2;
  localparam logic [2:0] OP_DRAIN = 3'd3;
  localparam logic [2:0] OP_HOLD  = 3'd4;   // Blocked write, host_in_ready held low

  typedef struct packed {
    logic [2:0] kind;
    reg_idx_t   idx;
    logic [7:0] arg;       // Pairs, halves or hold cycles
    logic [7:0] exp_val;   // Expected read value where fixed
  } step_t;

  logic                 userclk2;
  logic                 reset;
  axi_addr_beat_t       ar;
  logic                 arvalid;
  logic                 arready;
  axi_read_beat_t       r;
  logic                 rvalid;
  logic                 rready;
  axi_addr_beat_t       aw;
  logic                 awvalid;
  logic                 awready;
  axi_data_t            wdata;
  logic                 wvalid;
  logic                 wready;
  logic [AXI_ID_W-1:0]  bid;
  logic                 bvalid;
  logic                 bready;
  logic                 host_in_valid;
  logic                 host_in_ready;
  host_half_t           host_in_bits;
  logic                 host_out_valid;
  logic                 host_out_ready;
  host_half_t           host_out_bits;
  logic                 core_reset;

  step_t      steps[$];
  host_half_t in_model[$];    // Halves still due on host_in
  host_pair_t out_model[$];   // Pairs held in the host_out FIFO
  int         n_steps = 0;

  htif_bridge dut (
    .userclk2       (userclk2),
    .reset          (reset),
    .ar             (ar),
    .arvalid        (arvalid),
    .arready        (arready),
    .r              (r),
    .rvalid         (rvalid),
    .rready         (rready),
    .aw             (aw),
    .awvalid        (awvalid),
    .awready        (awready),
    .wdata          (wdata),
    .wvalid         (wvalid),
    .wready         (wready),
    .bid            (bid),
    .bvalid         (bvalid),
    .bready         (bready),
    .host_in_valid  (host_in_valid),
    .host_in_ready  (host_in_ready),
    .host_in_bits   (host_in_bits),
    .host_out_valid (host_out_valid),
    .host_out_ready (host_out_ready),
    .host_out_bits  (host_out_bits),
    .core_reset     (core_reset)
  );

  always #(PERIOD/2) userclk2 = ~userclk2;

  task automatic check(input string name, input logic [63:0] actual,
                       input logic [63:0] expected);
    if (actual !== expected)
    begin
      $display("FAIL at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic add_step(input logic [2:0] kind, input int idx, input int arg,
                          input int exp_val);
    step_t s;
    s.kind    = kind;
    s.idx     = reg_idx_t'(idx);
    s.arg     = 8'(arg);
    s.exp_val = 8'(exp_val);
    steps.push_back(s);
  endtask

  // ------------------------------------------------------------------
  // Chip side
  // ------------------------------------------------------------------
  task automatic drain_halves(input int n);
    int done;
    done = 0;
    while (done < n)
    begin
      @(negedge userclk2);
      host_in_ready = 1'b0;
      if (host_in_valid)
      begin
        check("host_in_bits", host_in_bits, in_model.pop_front());
        host_in_ready = 1'b1;   // Taken on the next rising edge
        done++;
      end
    end
    @(negedge userclk2);
    host_in_ready = 1'b0;
  endtask

  task automatic send_half(input host_half_t v);
    @(negedge userclk2);
    host_out_valid = 1'b0;
    while (!host_out_ready)
      @(negedge userclk2);
    host_out_valid = 1'b1;
    host_out_bits  = v;
  endtask

  task automatic push_pairs(input int n);
    host_pair_t p;
    repeat (n)
    begin
      p.lo = host_half_t'($urandom);   // First value sent
      p.hi = host_half_t'($urandom);
      send_half(p.lo);
      send_half(p.hi);
      out_model.push_back(p);
    end
    @(negedge userclk2);
    host_out_valid = 1'b0;
    check("host_out_ready", host_out_ready, out_model.size() < FIFO_DEPTH);
  endtask

  // ------------------------------------------------------------------
  // AXI side
  // ------------------------------------------------------------------
  task automatic axi_write(input reg_idx_t idx, input int hold);
    axi_data_t           data;
    logic [AXI_ID_W-1:0] id;
    logic                in_valid_before;
    data = axi_data_t'($urandom);
    id   = AXI_ID_W'($urandom);
    @(negedge userclk2);
    in_valid_before = host_in_valid;
    aw.id   = id;
    aw.addr = AXI_ADDR_W'(idx) << REG_IDX_LSB;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    if (hold > 0)
    begin
      repeat (hold)
      begin
        @(negedge userclk2);
        check("awready", awready, 1'b0);   // host_in full
        check("wready", wready, 1'b0);
        check("host_in_valid", host_in_valid, 1'b1);
      end
      drain_halves(2);
    end
    while (!awready)
      @(negedge userclk2);
    check("wready", wready, 1'b1);
    check("core_reset", core_reset, idx == RESET_IDX);
    if (idx == WFIFO_IDX)
    begin
      in_model.push_back(data[HOST_W-1:0]);   // Low half goes out first
      in_model.push_back(data[AXI_DATA_W-1:HOST_W]);
    end
    @(negedge userclk2);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    check("bvalid", bvalid, 1'b1);
    check("bid", bid, id);
    check("core_reset", core_reset, 1'b0);
    bready = 1'b1;
    @(negedge userclk2);
    bready = 1'b0;
    check("bvalid", bvalid, 1'b0);
    if (idx == RESET_IDX)
      check("host_in_valid", host_in_valid, in_valid_before);
  endtask

  task automatic axi_read(input reg_idx_t idx, input int exp_val);
    logic [AXI_ID_W-1:0] id;
    axi_data_t           expected;
    id = AXI_ID_W'($urandom);
    @(negedge userclk2);
    while (!arready)
      @(negedge userclk2);
    ar.id   = id;
    ar.addr = AXI_ADDR_W'(idx) << REG_IDX_LSB;
    arvalid = 1'b1;
    check("rvalid", rvalid, 1'b0);
    @(negedge userclk2);
    arvalid = 1'b0;
    check("rvalid", rvalid, 1'b1);   // One cycle after ar
    check("arready", arready, 1'b0);
    check("rid", r.id, id);
    if (idx == RFIFO_IDX)
      expected = out_model.pop_front();
    else
      expected = axi_data_t'(exp_val);
    check("rdata", r.data, expected);
    rready = 1'b1;
    @(negedge userclk2);
    rready = 1'b0;
    check("rvalid", rvalid, 1'b0);
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial
  begin
    int    i;
    step_t s;
    void'($urandom(43727));
    userclk2       = 1'b0;
    reset          = 1'b1;
    ar             = '0;
    arvalid        = 1'b0;
    rready         = 1'b0;
    aw             = '0;
    awvalid        = 1'b0;
    wdata          = '0;
    wvalid         = 1'b0;
    bready         = 1'b0;
    host_in_ready  = 1'b0;
    host_out_valid = 1'b0;
    host_out_bits  = '0;

    add_step(OP_READ, DCOUNT_IDX, 0, 0);
    for (i = 0; i < 4; i++)
      add_step(OP_WRITE, WFIFO_IDX, 0, 0);
    add_step(OP_DRAIN, 0, 8, 0);
    add_step(OP_PAIRS, 0, 3, 0);
    add_step(OP_READ, DCOUNT_IDX, 0, 3);
    add_step(OP_READ, RFIFO_IDX, 0, 0);
    add_step(OP_READ, RFIFO_IDX, 0, 0);
    add_step(OP_READ, DCOUNT_IDX, 0, 1);
    add_step(OP_READ, 5, 0, 0);   // Unmapped
    add_step(OP_READ, DCOUNT_IDX, 0, 1);
    add_step(OP_WRITE, WFIFO_IDX, 0, 0);
    add_step(OP_WRITE, RESET_IDX, 0, 0);
    add_step(OP_DRAIN, 0, 2, 0);
    for (i = 0; i < FIFO_DEPTH; i++)
      add_step(OP_WRITE, WFIFO_IDX, 0, 0);   // Fills host_in
    add_step(OP_HOLD, WFIFO_IDX, 6, 0);
    add_step(OP_DRAIN, 0, 2 * FIFO_DEPTH, 0);
    add_step(OP_PAIRS, 0, FIFO_DEPTH - 1, 0);
    add_step(OP_READ, DCOUNT_IDX, 0, FIFO_DEPTH);
    add_step(OP_READ, RFIFO_IDX, 0, 0);
    add_step(OP_READ, RFIFO_IDX, 0, 0);
    add_step(OP_READ, DCOUNT_IDX, 0, FIFO_DEPTH - 2);
    n_steps = steps.size();

    repeat (RESET_CYCLES)
      @(negedge userclk2);
    check("arready", arready, 1'b0);
    check("awready", awready, 1'b0);
    check("wready", wready, 1'b0);
    reset = 1'b0;
    @(negedge userclk2);
    check("host_in_valid", host_in_valid, 1'b0);
    check("core_reset", core_reset, 1'b0);
    check("rvalid", rvalid, 1'b0);
    check("bvalid", bvalid, 1'b0);
    check("arready", arready, 1'b1);

    for (i = 0; i < n_steps; i++)
    begin
      s = steps[i];
      case (s.kind)
        OP_WRITE: axi_write(s.idx, 0);
        OP_READ:  axi_read(s.idx, int'(s.exp_val));
        OP_PAIRS: push_pairs(int'(s.arg));
        OP_DRAIN: drain_halves(int'(s.arg));
        default:  axi_write(s.idx, int'(s.arg));
      endcase
    end

    $display("TESTS PASSED");
    $finish;
  end

  // Watchdog
  initial
  begin
    wait (n_steps > 0);
    repeat (n_steps * STEP_CYCLES + RESET_CYCLES)
      @(posedge userclk2);
    $display("Timeout: the run did not finish within %0d cycles",
             n_steps * STEP_CYCLES + RESET_CYCLES);
    $display("TESTS FAILED");
    $fatal(1);
  end

endmodule

`default_nettype wire

//--- vlog.f
hw/htif_pkg.sv
hw/sync_fifo.sv
hw/host_in_path.sv
hw/host_out_path.sv
hw/axi_reg_port.sv
hw/htif_bridge.sv
bench/htif_bridge_asserts.sv
bench/htif_bridge_tb.sv

//--- Bender.yml
package:
  name: htif_bridge

sources:
  - files:
      - hw/htif_pkg.sv
      - hw/sync_fifo.sv
      - hw/host_in_path.sv
      - hw/host_out_path.sv
      - hw/axi_reg_port.sv
      - hw/htif_bridge.sv
  - target: test
    files:
      - bench/htif_bridge_asserts.sv
      - bench/htif_bridge_tb.sv
